// ==== rv_pipe.f ====
rtl/rv_pipe_pkg.sv
rtl/rv_decode.sv
rtl/rv_reg_file.sv
rtl/rv_alu.sv
rtl/rv_forward_unit.sv
rtl/rv_pipe_top.sv
tb/rv_pipe_chk.sv
tb/tb_rv_pipe.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the rv_pipe testbench with Verilator, run it, and check the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=sim_rv_pipe

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_rv_pipe --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
  -f rv_pipe.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# the log decides the result
if grep -qx "TB PASSED" "$LOG_FILE"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $LOG_FILE"
exit 1

// ==== tb/tb_rv_pipe.sv ====
`default_nettype none

module tb_rv_pipe
  import rv_pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic                  clk = 1'b0;
  logic                  reset_i;
  logic                  inst_valid_i;
  logic                  inst_ready_o;
  logic [31:0]           inst_i;
  logic                  retire_valid_o;
  logic                  retire_ready_i;
  logic [xlen-1:0]       retire_pc_o;
  logic [reg_addr_w-1:0] retire_rd_o;
  logic [xlen-1:0]       retire_data_o;
  logic                  retire_we_o;
  logic                  retire_illegal_o;

  logic        bp_en;
  logic        gap_en;
  logic        timed_out;
  int          errors = 0;
  int          checks = 0;
  int          retired = 0;
  int          cycle = 0;
  logic [31:0] model_regs [32];
  logic [31:0] model_pc;

  // expected retire items in acceptance order
  logic [31:0] exp_pc_q [$];
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];
  logic        exp_we_q [$];
  logic        exp_ill_q [$];
  int          exp_cyc_q [$];

  rv_pipe_top i_rv_pipe_top (
    .clk              (clk),
    .reset_i          (reset_i),
    .inst_valid_i     (inst_valid_i),
    .inst_ready_o     (inst_ready_o),
    .inst_i           (inst_i),
    .retire_valid_o   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o),
    .retire_we_o      (retire_we_o),
    .retire_illegal_o (retire_illegal_o)
  );

  bind rv_pipe_top rv_pipe_chk i_rv_pipe_chk (
    .clk              (clk),
    .reset_i          (reset_i),
    .inst_ready_i     (inst_ready_o),
    .retire_valid_i   (retire_valid_o),
    .retire_ready_i   (retire_ready_i),
    .retire_pc_i      (retire_pc_o),
    .retire_rd_i      (retire_rd_o),
    .retire_data_i    (retire_data_o),
    .retire_we_i      (retire_we_o),
    .retire_illegal_i (retire_illegal_o)
  );

  always #20 clk = ~clk;

  // counts edges, stable at every rising edge
  always @(negedge clk) cycle++;

  // ============================================================
  // reference model
  // ============================================================

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic void ref_model(input logic [31:0] inst, input logic [31:0] pc,
                                    input logic [31:0] regs [32], output logic [4:0] rd,
                                    output logic [31:0] data, output logic we,
                                    output logic ill);
    logic [2:0] f3;
    logic [6:0] f7;
    f3   = inst[14:12];
    f7   = inst[31:25];
    rd   = inst[11:7];
    ill  = 1'b0;
    data = '0;
    case (inst[6:0])
      opc_op: begin
        // only ADD/SUB and SRL/SRA have a second funct7
        ill  = (f7 == 7'h20) ? !(f3 == 3'b000 || f3 == 3'b101) : (f7 != 7'h00);
        data = alu_ref(f3, f7[5], regs[inst[19:15]], regs[inst[24:20]]);
      end
      opc_op_imm: begin
        ill  = (f3 == 3'b001 && f7 != 7'h00) ||
               (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
        data = alu_ref(f3, f3 == 3'b101 && f7[5], regs[inst[19:15]],
                       {{20{inst[31]}}, inst[31:20]});
      end
      opc_lui:   data = {inst[31:12], 12'h000};
      opc_auipc: data = pc + {inst[31:12], 12'h000};
      default:   ill = 1'b1;
    endcase
    we = !ill;
  endfunction

  // ============================================================
  // encoders and random instructions
  // ============================================================

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc_op_imm};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [19:0] imm,
                                        input logic [4:0] rd);
    return {imm, rd, opc};
  endfunction

  function automatic logic [4:0] rand_rd();
    return 5'($urandom_range(31, 1));
  endfunction

  function automatic logic [31:0] rand_op(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [4:0] rd);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = 3'($urandom);
    f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 1) ? 7'h20 : 7'h00;
    return enc_r(f7, rs2, rs1, f3, rd);
  endfunction

  function automatic logic [31:0] rand_op_imm(input logic [4:0] rs1, input logic [4:0] rd);
    logic [2:0]  f3;
    logic [11:0] imm;
    f3  = 3'($urandom);
    imm = 12'($urandom);
    // shifts keep a legal funct7 above the shamt
    if (f3 == 3'b001) imm[11:5] = 7'h00;
    if (f3 == 3'b101) imm[11:5] = ($urandom % 2 == 1) ? 7'h20 : 7'h00;
    return enc_i(imm, rs1, f3, rd);
  endfunction

  function automatic logic [31:0] rand_any();
    int sel;
    sel = int'($urandom % 4);
    if (sel == 0) return rand_op_imm(5'($urandom), rand_rd());
    if (sel == 1) return enc_u(($urandom % 2 == 1) ? opc_lui : opc_auipc, 20'($urandom),
                               rand_rd());
    return rand_op(5'($urandom), 5'($urandom), rand_rd());
  endfunction

  // ============================================================
  // driving and checking
  // ============================================================

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  always @(posedge clk) begin : compare_retire
    int e_cyc;
    if (!reset_i && retire_valid_o && retire_ready_i) begin
      if (exp_pc_q.size() == 0) begin
        errors++;
        $display("retire at %0t with no instruction outstanding", $time);
      end else begin
        e_cyc = exp_cyc_q.pop_front();
        check_val("retire pc", retire_pc_o, exp_pc_q.pop_front());
        check_val("retire rd", 32'(retire_rd_o), 32'(exp_rd_q.pop_front()));
        check_val("write flag", 32'(retire_we_o), 32'(exp_we_q[0]));
        check_val("illegal flag", 32'(retire_illegal_o), 32'(exp_ill_q.pop_front()));
        // data of an illegal instruction means nothing
        if (exp_we_q.pop_front()) check_val("retire data", retire_data_o, exp_data_q[0]);
        void'(exp_data_q.pop_front());
        if (cycle - e_cyc < 3) begin
          errors++;
          $display("retire at %0t came %0d cycles after acceptance", $time, cycle - e_cyc);
        end
        retired++;
      end
    end
  end

  // called at edge plus 2 ns, returns at edge plus 2 ns
  task automatic send_inst(input logic [31:0] inst);
    int          waited;
    logic [4:0]  e_rd;
    logic [31:0] e_data;
    logic        e_we;
    logic        e_ill;
    if (timed_out) return;
    if (gap_en) begin
      inst_valid_i = 1'b0;
      repeat (int'($urandom % 3)) begin
        @(posedge clk);
        #2;
      end
    end
    inst_valid_i = 1'b1;
    inst_i       = inst;
    waited       = 0;
    @(posedge clk);
    while (!inst_ready_o && waited < 200) begin
      waited++;
      @(posedge clk);
    end
    if (!inst_ready_o) begin
      timed_out = 1'b1;
      $display("timeout: instruction %h was not accepted within 200 cycles", inst);
    end else begin
      ref_model(inst, model_pc, model_regs, e_rd, e_data, e_we, e_ill);
      if (e_we && e_rd != 5'd0) model_regs[e_rd] = e_data;
      exp_pc_q.push_back(model_pc);
      exp_rd_q.push_back(e_rd);
      exp_data_q.push_back(e_data);
      exp_we_q.push_back(e_we);
      exp_ill_q.push_back(e_ill);
      exp_cyc_q.push_back(cycle);
      model_pc = model_pc + 32'd4;
    end
    #2;
    inst_valid_i = 1'b0;
  endtask

  task automatic finish_test(input int num, input string name, input int err_before);
    int waited;
    waited = 0;
    @(negedge clk);
    while (exp_pc_q.size() != 0 && waited < 500) begin
      waited++;
      @(negedge clk);
    end
    if (exp_pc_q.size() != 0 && !timed_out) begin
      timed_out = 1'b1;
      $display("timeout: %0d instructions never retired", exp_pc_q.size());
    end
    @(posedge clk);
    #2;
    $display("test %0d %s finished with %0d errors", num, name, errors - err_before);
  endtask

  // ============================================================
  // test sequence
  // ============================================================

  initial begin : main_seq
    logic [6:0] bad_opc [7];
    logic [4:0] prev1;
    logic [4:0] prev2;
    logic [4:0] rd;
    int         err_mark;
    bad_opc = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111,
                7'b1100111, 7'b1110011, 7'b0001111};
    void'($urandom(32'h94b7_3e08));
    reset_i        = 1'b1;
    inst_valid_i   = 1'b0;
    inst_i         = nop_inst;
    retire_ready_i = 1'b1;
    bp_en          = 1'b0;
    gap_en         = 1'b0;
    timed_out      = 1'b0;
    model_pc       = '0;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    repeat (4) @(posedge clk);
    #2;
    reset_i = 1'b0;

    // fill every register, then random register-register ops
    err_mark = errors;
    for (int r = 1; r < 32; r++) begin
      send_inst(enc_u(opc_lui, 20'($urandom), 5'(r)));
      send_inst(enc_i(12'($urandom), 5'(r), 3'b000, 5'(r)));
    end
    for (int n = 0; n < 40; n++) send_inst(rand_op(5'($urandom), 5'($urandom), rand_rd()));
    finish_test(1, "register-register", err_mark);

    err_mark = errors;
    for (int n = 0; n < 40; n++) begin
      if (n % 2 == 0) send_inst(rand_op_imm(5'($urandom), rand_rd()));
      else send_inst(enc_u((n % 4 == 1) ? opc_lui : opc_auipc, 20'($urandom), rand_rd()));
    end
    finish_test(2, "immediate and upper", err_mark);

    // each source is the last rd or the one before
    err_mark = errors;
    prev1 = 5'd1;
    prev2 = 5'd2;
    for (int n = 0; n < 30; n++) begin
      rd = rand_rd();
      if (n % 2 == 0) send_inst(rand_op(($urandom % 2 == 1) ? prev1 : prev2, prev1, rd));
      else send_inst(rand_op_imm(($urandom % 2 == 1) ? prev2 : prev1, rd));
      prev2 = prev1;
      prev1 = rd;
    end
    finish_test(3, "dependent chains", err_mark);

    err_mark = errors;
    bp_en  = 1'b1;
    gap_en = 1'b1;
    for (int n = 0; n < 60; n++) send_inst(rand_any());
    bp_en  = 1'b0;
    gap_en = 1'b0;
    finish_test(4, "back-pressure and gaps", err_mark);

    // x9 must survive every illegal write, x10 reads it back
    err_mark = errors;
    for (int n = 0; n < 7; n++) send_inst({20'($urandom), 5'd9, bad_opc[n]});
    send_inst(enc_r(7'h01, 5'd3, 5'd4, 3'($urandom), 5'd9));
    send_inst(enc_r(7'h20, 5'd3, 5'd4, 3'b001, 5'd9));
    send_inst(enc_i({7'h20, 5'd3}, 5'd4, 3'b001, 5'd9));
    send_inst(enc_i({7'h10, 5'd3}, 5'd4, 3'b101, 5'd9));
    send_inst(enc_r(7'h00, 5'd0, 5'd9, 3'b000, 5'd10));
    finish_test(5, "illegal instructions", err_mark);

    err_mark = errors;
    send_inst(enc_i(12'h123, 5'd1, 3'b000, 5'd0));
    send_inst(enc_u(opc_lui, 20'hfffff, 5'd0));
    send_inst(rand_op(5'd2, 5'd3, 5'd0));
    send_inst(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd11));
    send_inst(enc_i(12'h005, 5'd0, 3'b000, 5'd12));
    send_inst(enc_r(7'h00, 5'd12, 5'd0, 3'b110, 5'd13));
    finish_test(6, "x0 writes", err_mark);

    $display("%0d checks, %0d retired, %0d errors, %0d outstanding",
             checks, retired, errors, exp_pc_q.size());
    if (errors == 0 && !timed_out && exp_pc_q.size() == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // retire back-pressure, random only while enabled
  initial begin : drive_retire_ready
    forever begin
      @(posedge clk);
      #2;
      retire_ready_i = bp_en ? (($urandom % 3) != 0) : 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== tb/rv_pipe_chk.sv ====
`default_nettype none

module rv_pipe_chk
  import rv_pipe_pkg::*;
(
  input logic                  clk,
  input logic                  reset_i,
  input logic                  inst_ready_i,
  input logic                  retire_valid_i,
  input logic                  retire_ready_i,
  input logic [xlen-1:0]       retire_pc_i,
  input logic [reg_addr_w-1:0] retire_rd_i,
  input logic [xlen-1:0]       retire_data_i,
  input logic                  retire_we_i,
  input logic                  retire_illegal_i
);

  timeunit 1ns;
  timeprecision 100ps;

  logic stalled;

  assign stalled = retire_valid_i && !retire_ready_i;

  // ============================================================
  // retire handshake
  // ============================================================

  // item held until the transfer
  retire_stable_a: assert property (
    @(posedge clk) disable iff (reset_i)
    stalled |=> retire_valid_i && $stable(retire_pc_i) && $stable(retire_rd_i)
      && $stable(retire_data_i) && $stable(retire_we_i) && $stable(retire_illegal_i)
  ) else $error("retire port changed under back-pressure");

  // input side frozen exactly while stalled
  ready_rule_a: assert property (
    @(posedge clk) disable iff (reset_i)
    inst_ready_i == !stalled
  ) else $error("inst_ready_o does not match the stall condition");

  reset_idle_a: assert property (
    @(posedge clk) reset_i |=> !retire_valid_i
  ) else $error("retire_valid_o high in the cycle after reset");

endmodule

`default_nettype wire

// ==== rtl/rv_pipe_top.sv ====
`default_nettype none

module rv_pipe_top
  import rv_pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  inst_valid_i,
  output logic                  inst_ready_o,
  input  logic [31:0]           inst_i,
  output logic                  retire_valid_o,
  input  logic                  retire_ready_i,
  output logic [xlen-1:0]       retire_pc_o,
  output logic [reg_addr_w-1:0] retire_rd_o,
  output logic [xlen-1:0]       retire_data_o,
  output logic                  retire_we_o,
  output logic                  retire_illegal_o
);

  logic stall;
  logic accept;
  logic [xlen-1:0] pc_q;

  // decode stage
  logic            id_valid_q;
  logic [xlen-1:0] id_pc_q;
  rv_inst_u        id_inst_q;
  alu_ctrl_e       id_alu_ctrl;
  logic [xlen-1:0] id_imm;
  logic            id_src_imm;
  logic            id_op1_pc;
  logic            id_reg_write;
  logic            id_illegal;
  logic [xlen-1:0] rf_rdata1;
  logic [xlen-1:0] rf_rdata2;
  logic [xlen-1:0] id_rdata1;
  logic [xlen-1:0] id_rdata2;
  logic            fwd1_id;
  logic            fwd2_id;

  // execute stage
  logic                  ex_valid_q;
  logic [xlen-1:0]       ex_pc_q;
  logic [reg_addr_w-1:0] ex_rs1_q;
  logic [reg_addr_w-1:0] ex_rs2_q;
  logic [reg_addr_w-1:0] ex_rd_q;
  logic [xlen-1:0]       ex_rdata1_q;
  logic [xlen-1:0]       ex_rdata2_q;
  logic [xlen-1:0]       ex_imm_q;
  alu_ctrl_e             ex_alu_ctrl_q;
  logic                  ex_src_imm_q;
  logic                  ex_op1_pc_q;
  logic                  ex_reg_write_q;
  logic                  ex_illegal_q;
  logic                  fwd1_ex;
  logic                  fwd2_ex;
  logic [xlen-1:0]       ex_src1;
  logic [xlen-1:0]       ex_src2;
  logic [xlen-1:0]       alu_op1;
  logic [xlen-1:0]       alu_op2;
  logic [xlen-1:0]       alu_result;

  // write-back stage
  logic                  wb_valid_q;
  logic [xlen-1:0]       wb_pc_q;
  logic [reg_addr_w-1:0] wb_rd_q;
  logic [xlen-1:0]       wb_data_q;
  logic                  wb_we_q;
  logic                  wb_illegal_q;
  logic                  wb_write;
  logic                  rf_we;

  // ============================================================
  // handshake and stall
  // ============================================================

  // retire back-pressure freezes all three stages
  assign stall        = retire_valid_o && !retire_ready_i;
  assign inst_ready_o = !stall;
  assign accept       = inst_valid_i && inst_ready_o;

  // control state, the decode register empties to a nop
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q       <= '0;
      id_valid_q <= 1'b0;
      id_inst_q  <= nop_inst;
      ex_valid_q <= 1'b0;
      wb_valid_q <= 1'b0;
    end else if (!stall) begin
      id_valid_q <= accept;
      id_inst_q  <= accept ? inst_i : nop_inst;
      ex_valid_q <= id_valid_q;
      wb_valid_q <= ex_valid_q;
      if (accept) begin
        pc_q <= pc_q + xlen'(4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      id_pc_q <= pc_q;
    end
  end

  // ============================================================
  // decode stage
  // ============================================================

  rv_decode i_rv_decode (
    .inst_i        (id_inst_q),
    .alu_ctrl_o    (id_alu_ctrl),
    .imm_o         (id_imm),
    .alu_src_imm_o (id_src_imm),
    .op1_pc_o      (id_op1_pc),
    .reg_write_o   (id_reg_write),
    .illegal_o     (id_illegal)
  );

  rv_reg_file i_rv_reg_file (
    .clk      (clk),
    .reset_i  (reset_i),
    .we_i     (rf_we),
    .waddr_i  (wb_rd_q),
    .wdata_i  (wb_data_q),
    .raddr1_i (id_inst_q.r_fmt.rs1),
    .raddr2_i (id_inst_q.r_fmt.rs2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2)
  );

  assign id_rdata1 = fwd1_id ? wb_data_q : rf_rdata1;
  assign id_rdata2 = fwd2_id ? wb_data_q : rf_rdata2;

  always_ff @(posedge clk) begin
    if (!stall) begin
      ex_pc_q        <= id_pc_q;
      ex_rs1_q       <= id_inst_q.r_fmt.rs1;
      ex_rs2_q       <= id_inst_q.r_fmt.rs2;
      ex_rd_q        <= id_inst_q.r_fmt.rd;
      ex_rdata1_q    <= id_rdata1;
      ex_rdata2_q    <= id_rdata2;
      ex_imm_q       <= id_imm;
      ex_alu_ctrl_q  <= id_alu_ctrl;
      ex_src_imm_q   <= id_src_imm;
      ex_op1_pc_q    <= id_op1_pc;
      ex_reg_write_q <= id_reg_write;
      ex_illegal_q   <= id_illegal;
    end
  end

  // ============================================================
  // execute stage
  // ============================================================

  rv_forward_unit i_rv_forward_unit (
    .rs1_id_i   (id_inst_q.r_fmt.rs1),
    .rs2_id_i   (id_inst_q.r_fmt.rs2),
    .rs1_ex_i   (ex_rs1_q),
    .rs2_ex_i   (ex_rs2_q),
    .rd_wb_i    (wb_rd_q),
    .wb_write_i (wb_write),
    .fwd1_id_o  (fwd1_id),
    .fwd2_id_o  (fwd2_id),
    .fwd1_ex_o  (fwd1_ex),
    .fwd2_ex_o  (fwd2_ex)
  );

  assign ex_src1 = fwd1_ex ? wb_data_q : ex_rdata1_q;
  assign ex_src2 = fwd2_ex ? wb_data_q : ex_rdata2_q;
  // AUIPC takes the PC, immediates replace rs2
  assign alu_op1 = ex_op1_pc_q ? ex_pc_q : ex_src1;
  assign alu_op2 = ex_src_imm_q ? ex_imm_q : ex_src2;

  rv_alu i_rv_alu (
    .alu_ctrl_i (ex_alu_ctrl_q),
    .op1_i      (alu_op1),
    .op2_i      (alu_op2),
    .result_o   (alu_result)
  );

  always_ff @(posedge clk) begin
    if (!stall) begin
      wb_pc_q      <= ex_pc_q;
      wb_rd_q      <= ex_rd_q;
      wb_data_q    <= alu_result;
      wb_we_q      <= ex_reg_write_q;
      wb_illegal_q <= ex_illegal_q;
    end
  end

  // ============================================================
  // write-back and retire
  // ============================================================

  assign wb_write = wb_valid_q && wb_we_q;
  // register file written on the retire transfer
  assign rf_we    = retire_valid_o && retire_ready_i && wb_we_q;

  assign retire_valid_o   = wb_valid_q;
  assign retire_pc_o      = wb_pc_q;
  assign retire_rd_o      = wb_rd_q;
  assign retire_data_o    = wb_data_q;
  assign retire_we_o      = wb_we_q;
  assign retire_illegal_o = wb_illegal_q;

endmodule

`default_nettype wire

// ==== rtl/rv_forward_unit.sv ====
`default_nettype none

module rv_forward_unit
  import rv_pipe_pkg::*;
(
  input  logic [reg_addr_w-1:0] rs1_id_i,
  input  logic [reg_addr_w-1:0] rs2_id_i,
  input  logic [reg_addr_w-1:0] rs1_ex_i,
  input  logic [reg_addr_w-1:0] rs2_ex_i,
  input  logic [reg_addr_w-1:0] rd_wb_i,
  input  logic                  wb_write_i,
  output logic                  fwd1_id_o,
  output logic                  fwd2_id_o,
  output logic                  fwd1_ex_o,
  output logic                  fwd2_ex_o
);

  // source matches a live, nonzero write-back destination
  function automatic logic wb_hit(input logic [reg_addr_w-1:0] rs);
    return wb_write_i && (rd_wb_i != '0) && (rs == rd_wb_i);
  endfunction

  // decode bypass, write-back result not yet in the register file
  assign fwd1_id_o = wb_hit(rs1_id_i);
  assign fwd2_id_o = wb_hit(rs2_id_i);

  // execute bypass, instruction one ahead
  assign fwd1_ex_o = wb_hit(rs1_ex_i);
  assign fwd2_ex_o = wb_hit(rs2_ex_i);

endmodule

`default_nettype wire

// ==== rtl/rv_alu.sv ====
`default_nettype none

module rv_alu
  import rv_pipe_pkg::*;
(
  input  alu_ctrl_e       alu_ctrl_i,
  input  logic [xlen-1:0] op1_i,
  input  logic [xlen-1:0] op2_i,
  output logic [xlen-1:0] result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shifts use the low five bits only
  assign shamt       = op2_i[4:0];
  assign lt_signed   = $signed(op1_i) < $signed(op2_i);
  assign lt_unsigned = op1_i < op2_i;

  always_comb begin
    case (alu_ctrl_i)
      alu_add:    result_o = op1_i + op2_i;
      alu_sub:    result_o = op1_i - op2_i;
      alu_sll:    result_o = op1_i << shamt;
      alu_slt:    result_o = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   result_o = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:    result_o = op1_i ^ op2_i;
      alu_srl:    result_o = op1_i >> shamt;
      alu_sra:    result_o = $unsigned($signed(op1_i) >>> shamt);
      alu_or:     result_o = op1_i | op2_i;
      alu_and:    result_o = op1_i & op2_i;
      // LUI path, immediate goes straight through
      alu_pass_b: result_o = op2_i;
      default:    result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/rv_reg_file.sv ====
`default_nettype none

module rv_reg_file
  import rv_pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  we_i,
  input  logic [reg_addr_w-1:0] waddr_i,
  input  logic [xlen-1:0]       wdata_i,
  input  logic [reg_addr_w-1:0] raddr1_i,
  input  logic [reg_addr_w-1:0] raddr2_i,
  output logic [xlen-1:0]       rdata1_o,
  output logic [xlen-1:0]       rdata2_o
);

  // x1 .. x31, x0 has no storage
  logic [xlen-1:0] regs [1:(2**reg_addr_w)-1];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // combinational read
  always_comb begin
    if (raddr1_i == '0) begin
      rdata1_o = '0;
    end else begin
      rdata1_o = regs[raddr1_i];
    end
    if (raddr2_i == '0) begin
      rdata2_o = '0;
    end else begin
      rdata2_o = regs[raddr2_i];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rv_decode.sv ====
`default_nettype none

module rv_decode
  import rv_pipe_pkg::*;
(
  input  rv_inst_u          inst_i,
  output alu_ctrl_e         alu_ctrl_o,
  output logic [xlen-1:0]   imm_o,
  output logic              alu_src_imm_o,
  output logic              op1_pc_o,
  output logic              reg_write_o,
  output logic              illegal_o
);

  logic [xlen-1:0] imm_i_type;
  logic [xlen-1:0] imm_u_type;
  logic [2:0]      funct3;
  logic [6:0]      funct7;

  // funct3 to ALU op, alt selects SUB or SRA
  function automatic alu_ctrl_e funct3_to_ctrl(input logic [2:0] f3, input logic alt);
    alu_ctrl_e ctrl;
    case (f3)
      3'b000:  ctrl = alt ? alu_sub : alu_add;
      3'b001:  ctrl = alu_sll;
      3'b010:  ctrl = alu_slt;
      3'b011:  ctrl = alu_sltu;
      3'b100:  ctrl = alu_xor;
      3'b101:  ctrl = alt ? alu_sra : alu_srl;
      3'b110:  ctrl = alu_or;
      default: ctrl = alu_and;
    endcase
    return ctrl;
  endfunction

  assign funct3 = inst_i.r_fmt.funct3;
  assign funct7 = inst_i.r_fmt.funct7;

  // immediates
  assign imm_i_type = {{(xlen-12){inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
  // U-type upper bits are imm, rs1 and funct3 of the I view
  assign imm_u_type = {inst_i.i_fmt.imm, inst_i.i_fmt.rs1, inst_i.i_fmt.funct3, 12'b0};

  always_comb begin
    alu_ctrl_o    = alu_add;
    imm_o         = imm_i_type;
    alu_src_imm_o = 1'b0;
    op1_pc_o      = 1'b0;
    reg_write_o   = 1'b0;
    illegal_o     = 1'b0;

    case (inst_i.r_fmt.opcode)
      opc_op: begin
        reg_write_o = 1'b1;
        alu_ctrl_o  = funct3_to_ctrl(funct3, funct7[5]);
        // only SUB and SRA take the alternate funct7
        if (funct7 == funct7_alt) begin
          if (funct3 != 3'b000 && funct3 != 3'b101) begin
            illegal_o = 1'b1;
          end
        end else if (funct7 != funct7_base) begin
          illegal_o = 1'b1;
        end
      end
      opc_op_imm: begin
        reg_write_o   = 1'b1;
        alu_src_imm_o = 1'b1;
        // no SUBI, upper imm bits only matter for shifts
        alu_ctrl_o    = funct3_to_ctrl(funct3, (funct3 == 3'b101) && funct7[5]);
        if (funct3 == 3'b001 && funct7 != funct7_base) begin
          illegal_o = 1'b1;
        end
        if (funct3 == 3'b101 && funct7 != funct7_base && funct7 != funct7_alt) begin
          illegal_o = 1'b1;
        end
      end
      opc_lui: begin
        reg_write_o   = 1'b1;
        alu_src_imm_o = 1'b1;
        imm_o         = imm_u_type;
        alu_ctrl_o    = alu_pass_b;
      end
      opc_auipc: begin
        reg_write_o   = 1'b1;
        alu_src_imm_o = 1'b1;
        op1_pc_o      = 1'b1;
        imm_o         = imm_u_type;
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase

    // illegal instructions retire without a write
    if (illegal_o) begin
      reg_write_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;

  // ============================================================
  // widths
  // ============================================================

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // ============================================================
  // opcodes and encodings
  // ============================================================

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;

  // funct7 for the base op and for SUB/SRA/SRAI
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  // addi x0, x0, 0
  localparam logic [31:0] nop_inst = 32'h0000_0013;

  // ============================================================
  // ALU control
  // ============================================================

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_ctrl_e;

  // one instruction word, seen as R-type or as I-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
  } rv_inst_u;

endpackage

`default_nettype wire
